// File: source/sensorPkg.sv
package sensorPkg;

	// ==============================
	// sizes and timing
	// ==============================
	localparam int numWheels = 4;
	localparam int windowCycles = 200; // scaled down so a run stays short
	localparam int glitchTicks = 4;    // tower ticks of dark that end a reception
	localparam int fifoDepth = 8;

	// left and right wheels are mounted mirrored
	localparam logic [numWheels-1:0] wheelPolarity = 4'b1010;

	localparam int countWidth = 16;
	localparam int posWidth = 8;
	localparam int wheelIdxWidth = $clog2(numWheels);
	localparam int ptrWidth = $clog2(fifoDepth); // depth is a power of two
	localparam int creditWidth = $clog2(fifoDepth + 1);
	localparam int timerWidth = $clog2(windowCycles);
	localparam int gapWidth = $clog2(glitchTicks + 1);

	// beacon filter states
	localparam logic [1:0] beaconWait = 2'd0;
	localparam logic [1:0] beaconRx = 2'd1;
	localparam logic [1:0] beaconGap = 2'd2;

	// ==============================
	// report word
	// ==============================
	typedef enum logic [1:0] {
		speed = 2'd0,
		beacon = 2'd1
	} reportTag;

	typedef struct packed {
		logic direction;
		logic [14:0] count; // half the edge count of the window
	} speedFields;

	typedef struct packed {
		logic [posWidth-1:0] startPos;
		logic [posWidth-1:0] endPos;
	} beaconFields;

	// same 16 bits, read according to the tag
	typedef union packed {
		speedFields speedView;
		beaconFields beaconView;
	} reportPayload;

	typedef struct packed {
		reportTag tag;
		logic [2:0] wheel;  // zero for beacon reports
		logic [3:0] seq;    // window number, wraps
		reportPayload payload;
	} reportWord;

endpackage

// File: source/reportLink.sv
interface reportLink (
	input logic clk
);

	// one word per valid cycle, one credit per freed slot
	logic valid;
	sensorPkg::reportWord word;
	logic creditReturn; // one-cycle pulse per freed slot

	// producing side spends credits
	modport sender (
		input clk,
		output valid,
		output word,
		input creditReturn
	);

	// consuming side hands credits back
	modport receiver (
		input clk,
		input valid,
		input word,
		output creditReturn
	);

endinterface

// File: source/encoderChannel.sv
module encoderChannel (
	input logic clk,
	input logic reset,
	input logic encA,
	input logic encB,
	input logic windowClear,
	output logic [sensorPkg::countWidth-1:0] edgeCount,
	output logic direction
);

	// [0] and [1] synchronize, [2] is the previous level
	logic [2:0] pipeA;
	logic [2:0] pipeB;
	logic riseA;
	logic riseB;
	logic [1:0] rises;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pipeA <= '0;
			pipeB <= '0;
		end else begin
			pipeA <= {pipeA[1:0], encA};
			pipeB <= {pipeB[1:0], encB};
		end
	end

	assign riseA = pipeA[1] & ~pipeA[2];
	assign riseB = pipeB[1] & ~pipeB[2];
	assign rises = {1'b0, riseA} + {1'b0, riseB};

	// ==============================
	// edge counter
	// ==============================
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			edgeCount <= '0;
		end else if (windowClear) begin
			edgeCount <= sensorPkg::countWidth'(rises); // edges on the clear cycle start the next window
		end else begin
			edgeCount <= edgeCount + sensorPkg::countWidth'(rises);
		end
	end

	// B level at a rising edge of A gives the turning sense
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			direction <= 1'b0;
		end else if (riseA) begin
			direction <= pipeB[1];
		end
	end

endmodule

// File: source/beaconFilter.sv
module beaconFilter (
	input logic clk,
	input logic reset,
	input logic towerTick,
	input logic towerSync,
	input logic laserSign,
	output logic done,
	output logic [sensorPkg::posWidth-1:0] startPos,
	output logic [sensorPkg::posWidth-1:0] endPos
);

	logic [2:0] tickPipe;
	logic [2:0] syncPipe;
	logic [2:0] laserPipe;
	logic tickRise;
	logic syncRise;
	logic laserRise;
	logic laserFall;
	logic [sensorPkg::posWidth-1:0] towerPos;
	logic [1:0] state;
	logic [sensorPkg::gapWidth-1:0] gapCount;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			tickPipe <= '0;
			syncPipe <= '0;
			laserPipe <= '0;
		end else begin
			tickPipe <= {tickPipe[1:0], towerTick};
			syncPipe <= {syncPipe[1:0], towerSync};
			laserPipe <= {laserPipe[1:0], laserSign};
		end
	end

	assign tickRise = tickPipe[1] & ~tickPipe[2];
	assign syncRise = syncPipe[1] & ~syncPipe[2];
	assign laserRise = laserPipe[1] & ~laserPipe[2];
	assign laserFall = ~laserPipe[1] & laserPipe[2];

	// tower angle in ticks since the last sync
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			towerPos <= '0;
		end else if (syncRise) begin
			towerPos <= '0;
		end else if (tickRise) begin
			towerPos <= towerPos + 1'b1;
		end
	end

	// ==============================
	// reception FSM
	// ==============================
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= sensorPkg::beaconWait;
			gapCount <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				sensorPkg::beaconWait: if (laserRise) state <= sensorPkg::beaconRx;
				sensorPkg::beaconRx: begin
					if (laserFall) begin
						gapCount <= '0;
						state <= sensorPkg::beaconGap;
					end
				end
				sensorPkg::beaconGap: begin
					if (laserRise) begin
						state <= sensorPkg::beaconRx; // dropout bridged
					end else if (tickRise) begin
						if (gapCount == sensorPkg::gapWidth'(sensorPkg::glitchTicks - 1)) begin
							done <= 1'b1;
							state <= sensorPkg::beaconWait;
						end else begin
							gapCount <= gapCount + 1'b1;
						end
					end
				end
				default: state <= sensorPkg::beaconWait;
			endcase
		end
	end

	// end is tentative until the gap runs out
	always_ff @(posedge clk) begin
		if (state == sensorPkg::beaconWait && laserRise) startPos <= towerPos;
		if (state == sensorPkg::beaconRx && laserFall) endPos <= towerPos;
	end

endmodule

// File: source/reportProducer.sv
module reportProducer (
	input logic clk,
	input logic reset,
	input logic [sensorPkg::numWheels-1:0][sensorPkg::countWidth-1:0] edgeCounts,
	input logic [sensorPkg::numWheels-1:0] directions,
	input logic beaconDone,
	input logic [sensorPkg::posWidth-1:0] beaconStart,
	input logic [sensorPkg::posWidth-1:0] beaconEnd,
	output logic windowClear,
	reportLink.sender link
);

	logic [sensorPkg::timerWidth-1:0] windowTimer;
	logic [3:0] windowSeq;
	logic [sensorPkg::creditWidth-1:0] credits;
	logic busy; // snapshot still has wheel reports to send
	logic [sensorPkg::wheelIdxWidth-1:0] sendIdx;
	logic [sensorPkg::numWheels-1:0][sensorPkg::countWidth-2:0] snapCount;
	logic [sensorPkg::numWheels-1:0] snapDir;
	logic [3:0] snapSeq;
	logic beaconFull;
	logic [sensorPkg::posWidth-1:0] holdStart;
	logic [sensorPkg::posWidth-1:0] holdEnd;
	logic sendBeacon;
	logic sendWheel;
	logic takeSnap;
	sensorPkg::reportWord nextWord;

	assign windowClear = windowTimer == sensorPkg::timerWidth'(sensorPkg::windowCycles - 1);
	assign takeSnap = windowClear & ~busy; // else the whole window is skipped
	assign sendBeacon = (credits != '0) & beaconFull;
	assign sendWheel = (credits != '0) & ~beaconFull & busy;

	always_comb begin
		nextWord = '0;
		if (sendBeacon) begin
			nextWord.tag = sensorPkg::beacon;
			nextWord.seq = windowSeq;
			nextWord.payload.beaconView.startPos = holdStart;
			nextWord.payload.beaconView.endPos = holdEnd;
		end else begin
			nextWord.tag = sensorPkg::speed;
			nextWord.wheel = 3'(sendIdx);
			nextWord.seq = snapSeq;
			nextWord.payload.speedView.direction = snapDir[sendIdx];
			nextWord.payload.speedView.count = snapCount[sendIdx];
		end
	end

	// ==============================
	// window timer and credits
	// ==============================
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			windowTimer <= '0;
			windowSeq <= '0;
			credits <= sensorPkg::creditWidth'(sensorPkg::fifoDepth);
			busy <= 1'b0;
			sendIdx <= '0;
			beaconFull <= 1'b0;
			link.valid <= 1'b0;
		end else begin
			windowTimer <= windowClear ? '0 : windowTimer + 1'b1;
			if (windowClear) windowSeq <= windowSeq + 1'b1;
			credits <= credits - sensorPkg::creditWidth'(sendBeacon | sendWheel)
				+ sensorPkg::creditWidth'(link.creditReturn);
			link.valid <= sendBeacon | sendWheel;
			if (takeSnap) begin
				busy <= 1'b1;
				sendIdx <= '0;
			end else if (sendWheel) begin
				if (sendIdx == sensorPkg::wheelIdxWidth'(sensorPkg::numWheels - 1)) busy <= 1'b0;
				else sendIdx <= sendIdx + 1'b1;
			end
			if (beaconDone) beaconFull <= 1'b1; // a newer reception overwrites
			else if (sendBeacon) beaconFull <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (takeSnap) begin
			for (int i = 0; i < sensorPkg::numWheels; i++) begin
				snapCount[i] <= edgeCounts[i][sensorPkg::countWidth-1:1]; // half always fits 15 bits
			end
			snapDir <= directions ^ sensorPkg::wheelPolarity;
			snapSeq <= windowSeq;
		end
		if (beaconDone) begin
			holdStart <= beaconStart;
			holdEnd <= beaconEnd;
		end
		if (sendBeacon | sendWheel) link.word <= nextWord;
	end

endmodule

// File: source/reportFifo.sv
module reportFifo (
	input logic clk,
	input logic reset,
	reportLink.receiver inLink,
	reportLink.sender outLink
);

	sensorPkg::reportWord mem [sensorPkg::fifoDepth];
	logic [sensorPkg::ptrWidth-1:0] wrPtr;
	logic [sensorPkg::ptrWidth-1:0] rdPtr;
	logic [sensorPkg::creditWidth-1:0] fill;
	logic outCredit; // the sender holds a single slot
	logic empty;
	logic pop;

	assign empty = fill == '0;
	// an empty buffer forwards the incoming word in the same cycle
	assign pop = outCredit & (~empty | inLink.valid);

	// ==============================
	// storage
	// ==============================
	always_ff @(posedge clk) begin
		if (inLink.valid) mem[wrPtr] <= inLink.word; // upstream credit guarantees room
		if (pop) outLink.word <= empty ? inLink.word : mem[rdPtr];
	end

	// pointers wrap on their own
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
			fill <= '0;
			outCredit <= 1'b1;
			outLink.valid <= 1'b0;
			inLink.creditReturn <= 1'b0;
		end else begin
			wrPtr <= wrPtr + sensorPkg::ptrWidth'(inLink.valid);
			rdPtr <= rdPtr + sensorPkg::ptrWidth'(pop);
			fill <= fill + sensorPkg::creditWidth'(inLink.valid)
				- sensorPkg::creditWidth'(pop);
			outCredit <= (outCredit & ~pop) | outLink.creditReturn;
			outLink.valid <= pop;
			inLink.creditReturn <= pop; // slot freed
		end
	end

endmodule

// File: source/hostSender.sv
module hostSender (
	input logic clk,
	input logic reset,
	reportLink.receiver link,
	input logic reportReady,
	output logic reportValid,
	output sensorPkg::reportWord reportWord
);

	logic taken;

	assign taken = reportValid & reportReady;

	// ==============================
	// host handshake
	// ==============================
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			reportValid <= 1'b0;
			link.creditReturn <= 1'b0;
		end else begin
			if (link.valid) begin
				reportValid <= 1'b1;
			end else if (taken) begin
				reportValid <= 1'b0;
			end
			link.creditReturn <= taken; // buffer free again
		end
	end

	// word only changes once the previous one is gone
	always_ff @(posedge clk) begin
		if (link.valid) reportWord <= link.word;
	end

endmodule

// File: source/sensorHub.sv
module sensorHub (
	input logic clk,
	input logic reset,
	input logic [sensorPkg::numWheels-1:0] encA,
	input logic [sensorPkg::numWheels-1:0] encB,
	input logic towerTick,
	input logic towerSync,
	input logic laserSign,
	input logic reportReady,
	output logic reportValid,
	output sensorPkg::reportWord reportWord
);

	logic [sensorPkg::numWheels-1:0][sensorPkg::countWidth-1:0] edgeCounts;
	logic [sensorPkg::numWheels-1:0] directions;
	logic windowClear;
	logic beaconDone;
	logic [sensorPkg::posWidth-1:0] beaconStart;
	logic [sensorPkg::posWidth-1:0] beaconEnd;

	reportLink prodLink (.clk(clk));
	reportLink sendLink (.clk(clk));

	// ==============================
	// measurement
	// ==============================
	for (genvar w = 0; w < sensorPkg::numWheels; w++) begin : wheel
		encoderChannel i_encoder (
			.clk(clk),
			.reset(reset),
			.encA(encA[w]),
			.encB(encB[w]),
			.windowClear(windowClear),
			.edgeCount(edgeCounts[w]),
			.direction(directions[w])
		);
	end

	beaconFilter i_beacon (
		.clk(clk),
		.reset(reset),
		.towerTick(towerTick),
		.towerSync(towerSync),
		.laserSign(laserSign),
		.done(beaconDone),
		.startPos(beaconStart),
		.endPos(beaconEnd)
	);

	// ==============================
	// report path
	// ==============================
	reportProducer i_producer (
		.clk(clk),
		.reset(reset),
		.edgeCounts(edgeCounts),
		.directions(directions),
		.beaconDone(beaconDone),
		.beaconStart(beaconStart),
		.beaconEnd(beaconEnd),
		.windowClear(windowClear),
		.link(prodLink.sender)
	);

	reportFifo i_fifo (
		.clk(clk),
		.reset(reset),
		.inLink(prodLink.receiver),
		.outLink(sendLink.sender)
	);

	hostSender i_sender (
		.clk(clk),
		.reset(reset),
		.link(sendLink.receiver),
		.reportReady(reportReady),
		.reportValid(reportValid),
		.reportWord(reportWord)
	);

endmodule

// File: test/sensorModel.svh
`ifndef sensorModelSvh
`define sensorModelSvh

// ==============================
// wheel model
// ==============================
int edgeTally [16][sensorPkg::numWheels]; // edges per window, slot is seq number
logic dirAtEnd [16][sensorPkg::numWheels]; // direction after polarity, at window end
logic [sensorPkg::numWheels-1:0] curDir;
logic [sensorPkg::numWheels-1:0] lastA;
logic [sensorPkg::numWheels-1:0] lastB;

// beacon model, driven levels one cycle back
logic lastTick;
logic lastSync;
logic lastLaser;
logic [7:0] towerAngle;
int rxState; // 0 waiting, 1 receiving, 2 in a gap
int gapTicks;
int bridgedGaps;
logic [7:0] startMark;
logic [7:0] endMark;
logic [15:0] expBeacons [$]; // start in the upper byte, end in the lower

task automatic clearModel();
	lastA = '0;
	lastB = '0;
	curDir = '0;
	lastTick = 1'b0;
	lastSync = 1'b0;
	lastLaser = 1'b0;
	towerAngle = '0;
	rxState = 0;
	gapTicks = 0;
	bridgedGaps = 0;
	expBeacons.delete();
endtask

// rises on both channels count, B level at an A rise is the direction
task automatic countEncoderEdges(input int win, input logic [sensorPkg::numWheels-1:0] a,
		input logic [sensorPkg::numWheels-1:0] b);
	for (int w = 0; w < sensorPkg::numWheels; w++) begin
		if (a[w] && !lastA[w]) begin
			edgeTally[win % 16][w]++;
			curDir[w] = b[w];
		end
		if (b[w] && !lastB[w]) edgeTally[win % 16][w]++;
	end
	lastA = a;
	lastB = b;
endtask

task automatic closeWindow(input int win);
	for (int w = 0; w < sensorPkg::numWheels; w++) begin
		dirAtEnd[win % 16][w] = curDir[w] ^ sensorPkg::wheelPolarity[w];
	end
endtask

function automatic int expectedCount(input int win, input int w);
	int half;
	half = edgeTally[win % 16][w] / 2;
	return (half > 32767) ? 32767 : half; // 15-bit field
endfunction

task automatic trackBeacon(input logic tick, input logic sync, input logic laser);
	logic tickRise;
	logic syncRise;
	logic laserRise;
	logic laserFall;
	tickRise = tick & ~lastTick;
	syncRise = sync & ~lastSync;
	laserRise = laser & ~lastLaser;
	laserFall = ~laser & lastLaser;
	case (rxState)
		0: begin
			if (laserRise) begin
				startMark = towerAngle;
				rxState = 1;
			end
		end
		1: begin
			if (laserFall) begin
				endMark = towerAngle; // tentative
				gapTicks = 0;
				rxState = 2;
			end
		end
		default: begin
			if (laserRise) begin
				bridgedGaps++;
				rxState = 1;
			end else if (tickRise) begin
				gapTicks++;
				if (gapTicks == sensorPkg::glitchTicks) begin
					expBeacons.push_back({startMark, endMark});
					rxState = 0;
				end
			end
		end
	endcase
	if (syncRise) towerAngle = 8'd0;
	else if (tickRise) towerAngle = towerAngle + 8'd1;
	lastTick = tick;
	lastSync = sync;
	lastLaser = laser;
endtask

`endif

// File: test/sensorHubTb.sv
module sensorHubTb;

	localparam int windowsDriven = 12;
	localparam int stopCycle = windowsDriven * sensorPkg::windowCycles;
	localparam int margin = 4000;

	logic clk;
	logic reset;
	logic [sensorPkg::numWheels-1:0] encA;
	logic [sensorPkg::numWheels-1:0] encB;
	logic towerTick;
	logic towerSync;
	logic laserSign;
	logic reportReady;
	logic reportValid;
	sensorPkg::reportWord reportWord;

	int cyc; // cycles since reset release
	int checks [5];
	int errors [5];
	int curSeq = -1;
	int nextWheel = 0;
	int skipped = 0;
	bit wheelsDone = 1'b0;
	bit stalled = 1'b0;
	sensorPkg::reportWord heldWord;

	`include "sensorModel.svh"

	sensorHub i_dut (
		.clk(clk),
		.reset(reset),
		.encA(encA),
		.encB(encB),
		.towerTick(towerTick),
		.towerSync(towerSync),
		.laserSign(laserSign),
		.reportReady(reportReady),
		.reportValid(reportValid),
		.reportWord(reportWord)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic reportMismatch(input int t, input string msg);
		errors[t]++;
		$display("FAILED at time %0t: %s", $time, msg);
	endtask

	task automatic printTestLine(input int t, input string name);
		$display("[%0d] %s: %0d checks, %0d errors", t + 1, name, checks[t], errors[t]);
	endtask

	// ==============================
	// report checks
	// ==============================
	task automatic takeReport(input sensorPkg::reportWord rw);
		int s;
		int w;
		s = int'(rw.seq);
		w = int'(rw.wheel);
		if (rw.tag == sensorPkg::speed) begin
			checks[4]++;
			if (w >= sensorPkg::numWheels) begin
				reportMismatch(4, $sformatf("wheel index %0d out of range", w));
				return;
			end
			if (nextWheel == 0 && w == 0 && s > curSeq) begin
				skipped += s - curSeq - 1; // whole windows only
			end else if (w != nextWheel || s != curSeq) begin
				reportMismatch(4, $sformatf("wheel %0d seq %0d out of order, expected wheel %0d seq %0d",
					w, s, nextWheel, curSeq));
			end
			curSeq = s;
			nextWheel = (w + 1) % sensorPkg::numWheels;
			checks[1]++;
			if (int'(rw.payload.speedView.count) != expectedCount(s, w)) begin
				reportMismatch(1, $sformatf("wheel %0d seq %0d count %0d, expected %0d", w, s,
					rw.payload.speedView.count, expectedCount(s, w)));
			end
			checks[2]++;
			if (rw.payload.speedView.direction != dirAtEnd[s % 16][w]) begin
				reportMismatch(2, $sformatf("wheel %0d seq %0d direction %0b, expected %0b", w, s,
					rw.payload.speedView.direction, dirAtEnd[s % 16][w]));
			end
			if (w == sensorPkg::numWheels - 1 && s >= windowsDriven - 1) wheelsDone = 1'b1;
		end else if (rw.tag == sensorPkg::beacon) begin
			checks[3]++;
			if (expBeacons.size() == 0) begin
				errors[3]++;
				$display("beacon report at time %0t with no reception in the model", $time);
			end else begin
				if ({rw.payload.beaconView.startPos, rw.payload.beaconView.endPos} != expBeacons[0]
						|| rw.wheel != 3'd0) begin
					reportMismatch(3, $sformatf("beacon %h, expected %h", rw.payload, expBeacons[0]));
				end
				void'(expBeacons.pop_front());
			end
		end else begin
			reportMismatch(4, $sformatf("unknown tag %0d", rw.tag));
		end
	endtask

	// host side, sampled on the edge
	always @(posedge clk) begin
		if (reset || cyc <= sensorPkg::windowCycles) begin
			checks[0]++;
			if (reportValid) reportMismatch(0, "reportValid high before the first window closed");
		end
		if (!reset && cyc == sensorPkg::windowCycles) printTestLine(0, "quiet after reset");
		if (stalled) begin
			checks[4]++;
			if (!reportValid || reportWord != heldWord) begin
				reportMismatch(4, "word changed or dropped while the host stalled");
			end
		end
		if (reportValid && reportReady) takeReport(reportWord);
		stalled = reportValid && !reportReady;
		heldWord = reportWord;
	end

	// ==============================
	// stimulus
	// ==============================
	initial begin
		int c;
		int phase;
		int laserHold;
		int encHold [2][sensorPkg::numWheels];
		logic [sensorPkg::numWheels-1:0] nextA;
		logic [sensorPkg::numWheels-1:0] nextB;
		logic nextTick;
		logic nextSync;
		logic nextLaser;
		bit laneOpen;
		void'($urandom(19));
		reset = 1'b1;
		encA = '0;
		encB = '0;
		towerTick = 1'b0;
		towerSync = 1'b0;
		laserSign = 1'b0;
		reportReady = 1'b0;
		cyc = 0;
		clearModel();
		nextA = '0;
		nextB = '0;
		nextTick = 1'b0;
		nextSync = 1'b0;
		nextLaser = 1'b0;
		laserHold = 10;
		for (int w = 0; w < sensorPkg::numWheels; w++) begin
			encHold[0][w] = 4 + int'($urandom % 12);
			encHold[1][w] = 4 + int'($urandom % 12);
		end
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		cyc <= 1;
		forever begin
			@(posedge clk);
			c = cyc;
			phase = c % sensorPkg::windowCycles;
			laneOpen = phase >= 6 && phase <= sensorPkg::windowCycles - 6 && c < stopCycle;
			for (int w = 0; w < sensorPkg::numWheels; w++) begin
				encHold[0][w]--;
				encHold[1][w]--;
				if (laneOpen && encHold[0][w] <= 0) begin
					nextA[w] = ~nextA[w];
					encHold[0][w] = 4 + int'($urandom % 12);
				end
				if (laneOpen && encHold[1][w] <= 0) begin
					nextB[w] = ~nextB[w];
					encHold[1][w] = 4 + int'($urandom % 12);
				end
			end
			if (c % 4 == 0) nextTick = ~nextTick; // one tick every 8 cycles
			if (c % 512 == 1) nextSync = 1'b1;
			if (c % 512 == 9) nextSync = 1'b0;
			laserHold--;
			// laser moves between tick edges so positions are unambiguous
			// and stays dark in the first window, which must not report
			if (laneOpen && c >= sensorPkg::windowCycles && c % 4 == 2 && laserHold <= 0) begin
				nextLaser = ~nextLaser;
				laserHold = nextLaser ? 8 + int'($urandom % 32) : 8 + int'($urandom % 64);
			end else if (c >= stopCycle && c % 4 == 2 && phase >= 6 && nextLaser) begin
				nextLaser = 1'b0; // let the last reception finish
			end
			encA <= nextA;
			encB <= nextB;
			towerTick <= nextTick;
			towerSync <= nextSync;
			laserSign <= nextLaser;
			reportReady <= 1'($urandom % 2);
			countEncoderEdges(c / sensorPkg::windowCycles, nextA, nextB);
			trackBeacon(nextTick, nextSync, nextLaser);
			if (phase == sensorPkg::windowCycles - 1) closeWindow(c / sensorPkg::windowCycles);
			cyc <= c + 1;
		end
	end

	// ==============================
	// end of run
	// ==============================
	initial begin
		int failedTests;
		int totalChecks;
		int totalErrors;
		failedTests = 0;
		totalChecks = 0;
		totalErrors = 0;
		wait (cyc > stopCycle);
		while (!(wheelsDone && expBeacons.size() == 0)) @(posedge clk);
		repeat (40) @(posedge clk); // catch stray reports
		printTestLine(1, "wheel counts");
		printTestLine(2, "wheel directions");
		printTestLine(3, $sformatf("beacon receptions, %0d gaps bridged", bridgedGaps));
		printTestLine(4, $sformatf("order and integrity, %0d windows skipped", skipped));
		for (int t = 0; t < 5; t++) begin
			totalChecks += checks[t];
			totalErrors += errors[t];
			if (errors[t] != 0) failedTests++;
		end
		$display("summary: %0d of 5 tests with errors, %0d checks, %0d errors",
			failedTests, totalChecks, totalErrors);
		if (totalErrors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	initial begin
		#((windowsDriven + 3) * sensorPkg::windowCycles * 40 + margin);
		$display("watchdog expired at time %0t with reports still missing", $time);
		$display("test failed");
		$finish;
	end

endmodule

// File: src.f
+incdir+test
source/sensorPkg.sv
source/reportLink.sv
source/encoderChannel.sv
source/beaconFilter.sv
source/reportProducer.sv
source/reportFifo.sv
source/hostSender.sv
source/sensorHub.sv
test/sensorHubTb.sv

// File: Makefile
.PHONY: sim clean

# build, run, then decide on the log contents
sim:
	verilator --binary --timing -j 0 --top-module sensorHubTb -f src.f --Mdir obj_dir -o sensorHubTb
	./obj_dir/sensorHubTb | tee sim.log
	grep -q "test passed" sim.log

clean:
	rm -rf obj_dir sim.log
